// File: side_ch_pkg.sv
// side channel shared definitions
package side_ch_pkg;

	localparam int BUF_AW = 10; // 1024 samples
	localparam int LEN_W = 14;
	localparam int RSSI_W = 11;
	localparam int GAIN_W = 7;
	localparam int APB_AW = 5;
	localparam int MAX_DMA_WORDS = 8188; // 65507 byte udp payload / 8

	typedef logic [31:0] iq_w_t; // q in high half, i in low half
	typedef logic [63:0] word_t;
	typedef logic [63:0] tsf_t;
	typedef logic [BUF_AW-1:0] addr_t;
	typedef logic [LEN_W-1:0] len_t;
	typedef logic signed [RSSI_W-1:0] rssi_t; // half dB steps
	typedef logic [7:0] gpio_t; // lock in bit 7, gain below
	typedef logic [GAIN_W-1:0] gain_t;
	typedef logic [APB_AW-1:0] apb_addr_t;
	typedef logic [31:0] apb_data_t;

	localparam apb_addr_t REG_CTRL = 5'h00;
	localparam apb_addr_t REG_TRIG = 5'h04;
	localparam apb_addr_t REG_TH = 5'h08;
	localparam apb_addr_t REG_PRE = 5'h0c;
	localparam apb_addr_t REG_LEN = 5'h10;

	typedef enum logic [3:0] {
		TRIG_FCS_ANY = 4'd0,
		TRIG_FCS_OK = 4'd1,
		TRIG_FCS_BAD = 4'd2,
		TRIG_HEADER_STROBE = 4'd3,
		TRIG_LONG_PREAMBLE = 4'd4,
		TRIG_SHORT_PREAMBLE = 4'd5,
		TRIG_RSSI_RISE = 4'd6,
		TRIG_RSSI_FALL = 4'd7,
		TRIG_AGC_UNLOCK = 4'd8,
		TRIG_AGC_LOCK = 4'd9,
		TRIG_GAIN_RISE = 4'd10,
		TRIG_GAIN_FALL = 4'd11,
		TRIG_TX_STARTED = 4'd12,
		TRIG_TX_DONE = 4'd13,
		TRIG_TX_BB_RISE = 4'd14,
		TRIG_TX_BB_FALL = 4'd15
	} trig_sel_t;

	typedef enum logic [1:0] {WAIT, PREPARE, HEADER, STREAM} cap_state_t;

endpackage

// File: side_ch_cfg_if.sv
// capture configuration bundle
`timescale 1ns/10ps

interface side_ch_cfg_if;

	logic capture_en;
	logic status_mode; // 0 iq pair, 1 iq0 plus agc status
	side_ch_pkg::trig_sel_t trig_sel;
	side_ch_pkg::rssi_t rssi_th;
	side_ch_pkg::gain_t gain_th;
	side_ch_pkg::len_t pre_len; // samples kept before trigger
	side_ch_pkg::len_t iq_len; // samples per burst

	modport regs (
		output capture_en, status_mode, trig_sel, rssi_th, gain_th, pre_len, iq_len
	);

	modport trig (input capture_en, trig_sel, rssi_th, gain_th);

	modport seq (input capture_en, status_mode, pre_len, iq_len);

endinterface

// File: side_ch_regs.sv
// capture control registers
`timescale 1ns/10ps

module side_ch_regs (
	input logic clk,
	input logic rstn,
	input side_ch_pkg::apb_addr_t paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input side_ch_pkg::apb_data_t pwdata,
	output side_ch_pkg::apb_data_t prdata,
	output logic pready,
	output logic start_trans,
	side_ch_cfg_if.regs cfg
);

	logic wr_en;

	assign wr_en = psel && penable && pwrite; // access phase
	assign pready = 1'b1;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			cfg.capture_en <= 1'b0;
			cfg.status_mode <= 1'b0;
			cfg.trig_sel <= side_ch_pkg::TRIG_FCS_ANY;
			cfg.rssi_th <= '0;
			cfg.gain_th <= '0;
			cfg.pre_len <= '0;
			cfg.iq_len <= '0;
			start_trans <= 1'b0;
		end else begin
			// dma kick once the burst length is known
			start_trans <= wr_en && (paddr == side_ch_pkg::REG_LEN);
			if (wr_en) begin
				case (paddr)
					side_ch_pkg::REG_CTRL: begin
						cfg.capture_en <= pwdata[0];
						cfg.status_mode <= pwdata[1];
					end
					side_ch_pkg::REG_TRIG: cfg.trig_sel <= side_ch_pkg::trig_sel_t'(pwdata[3:0]);
					side_ch_pkg::REG_TH: begin
						cfg.rssi_th <= pwdata[10:0];
						cfg.gain_th <= pwdata[22:16];
					end
					side_ch_pkg::REG_PRE: cfg.pre_len <= pwdata[13:0];
					side_ch_pkg::REG_LEN: cfg.iq_len <= pwdata[13:0];
					default: ; // unmapped
				endcase
			end
		end
	end

	always_comb begin
		prdata = '0;
		case (paddr)
			side_ch_pkg::REG_CTRL: prdata = {30'd0, cfg.status_mode, cfg.capture_en};
			side_ch_pkg::REG_TRIG: prdata = {28'd0, cfg.trig_sel};
			side_ch_pkg::REG_TH: prdata = {9'd0, cfg.gain_th, 5'd0, cfg.rssi_th};
			side_ch_pkg::REG_PRE: prdata = {18'd0, cfg.pre_len};
			side_ch_pkg::REG_LEN: prdata = {18'd0, cfg.iq_len};
			default: prdata = '0;
		endcase
	end

	// apb access needs a setup phase, so two length writes cannot be adjacent
	a_start_single: assert property (
		@(posedge clk) disable iff (!rstn) start_trans |=> !start_trans
	);

endmodule

// File: iq_trigger_detect.sv
// capture trigger selection
`timescale 1ns/10ps

module iq_trigger_detect (
	input logic clk,
	input logic rstn,
	side_ch_cfg_if.trig cfg,
	input logic fcs_in_strobe,
	input logic fcs_ok,
	input logic pkt_header_valid_strobe,
	input logic long_preamble_detected,
	input logic short_preamble_detected,
	input logic phy_tx_started,
	input logic phy_tx_done,
	input logic tx_bb_is_ongoing,
	input side_ch_pkg::rssi_t rssi_half_db,
	input side_ch_pkg::gpio_t gpio_status,
	output logic trigger
);

	side_ch_pkg::rssi_t rssi_q;
	side_ch_pkg::gpio_t gpio_q;
	logic tx_bb_q;
	logic rssi_rise;
	logic rssi_fall;
	logic agc_unlock;
	logic agc_lock;
	logic gain_rise;
	logic gain_fall;
	logic tx_bb_rise;
	logic tx_bb_fall;
	logic sel;

	// copies keep tracking while disabled so no stale edge shows on enable
	always_ff @(posedge clk) begin
		if (!rstn) begin
			rssi_q <= '0;
			gpio_q <= '0;
			tx_bb_q <= 1'b0;
		end else begin
			rssi_q <= rssi_half_db;
			gpio_q <= gpio_status;
			tx_bb_q <= tx_bb_is_ongoing;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn || !cfg.capture_en) begin
			rssi_rise <= 1'b0;
			rssi_fall <= 1'b0;
			agc_unlock <= 1'b0;
			agc_lock <= 1'b0;
			gain_rise <= 1'b0;
			gain_fall <= 1'b0;
			tx_bb_rise <= 1'b0;
			tx_bb_fall <= 1'b0;
		end else begin
			rssi_rise <= (rssi_q < cfg.rssi_th) && (rssi_half_db >= cfg.rssi_th);
			rssi_fall <= (rssi_q >= cfg.rssi_th) && (rssi_half_db < cfg.rssi_th);
			agc_unlock <= gpio_q[7] && !gpio_status[7];
			agc_lock <= !gpio_q[7] && gpio_status[7];
			gain_rise <= (gpio_q[6:0] < cfg.gain_th) && (gpio_status[6:0] >= cfg.gain_th);
			gain_fall <= (gpio_q[6:0] >= cfg.gain_th) && (gpio_status[6:0] < cfg.gain_th);
			tx_bb_rise <= !tx_bb_q && tx_bb_is_ongoing;
			tx_bb_fall <= tx_bb_q && !tx_bb_is_ongoing;
		end
	end

	always_comb begin
		sel = 1'b0;
		case (cfg.trig_sel)
			side_ch_pkg::TRIG_FCS_ANY: sel = fcs_in_strobe;
			side_ch_pkg::TRIG_FCS_OK: sel = fcs_in_strobe && fcs_ok;
			side_ch_pkg::TRIG_FCS_BAD: sel = fcs_in_strobe && !fcs_ok;
			side_ch_pkg::TRIG_HEADER_STROBE: sel = pkt_header_valid_strobe;
			side_ch_pkg::TRIG_LONG_PREAMBLE: sel = long_preamble_detected;
			side_ch_pkg::TRIG_SHORT_PREAMBLE: sel = short_preamble_detected;
			side_ch_pkg::TRIG_RSSI_RISE: sel = rssi_rise;
			side_ch_pkg::TRIG_RSSI_FALL: sel = rssi_fall;
			side_ch_pkg::TRIG_AGC_UNLOCK: sel = agc_unlock;
			side_ch_pkg::TRIG_AGC_LOCK: sel = agc_lock;
			side_ch_pkg::TRIG_GAIN_RISE: sel = gain_rise;
			side_ch_pkg::TRIG_GAIN_FALL: sel = gain_fall;
			side_ch_pkg::TRIG_TX_STARTED: sel = phy_tx_started;
			side_ch_pkg::TRIG_TX_DONE: sel = phy_tx_done;
			side_ch_pkg::TRIG_TX_BB_RISE: sel = tx_bb_rise;
			side_ch_pkg::TRIG_TX_BB_FALL: sel = tx_bb_fall;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			trigger <= 1'b0;
		end else begin
			trigger <= sel && cfg.capture_en;
		end
	end

endmodule

// File: iq_ring_buffer.sv
// circular iq sample memory
`timescale 1ns/10ps

module iq_ring_buffer (
	input logic clk,
	input logic rstn,
	input logic wr_en,
	input side_ch_pkg::word_t wr_data,
	output side_ch_pkg::addr_t wr_ptr,
	input side_ch_pkg::addr_t rd_addr,
	output side_ch_pkg::word_t rd_data
);

	side_ch_pkg::word_t mem [2**side_ch_pkg::BUF_AW];

	// free running, wraps at buffer size
	always_ff @(posedge clk) begin
		if (!rstn) begin
			wr_ptr <= '0;
		end else if (wr_en) begin
			wr_ptr <= wr_ptr + side_ch_pkg::addr_t'(1);
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= wr_data;
		end
		rd_data <= mem[rd_addr]; // one cycle read
	end

endmodule

// File: iq_capture_seq.sv
// capture burst sequencer
`timescale 1ns/10ps

module iq_capture_seq (
	input logic clk,
	input logic rstn,
	side_ch_cfg_if.seq cfg,
	input logic trigger,
	input logic iq_strobe,
	input side_ch_pkg::iq_w_t iq0,
	input side_ch_pkg::iq_w_t iq1,
	input side_ch_pkg::rssi_t rssi_half_db,
	input side_ch_pkg::gpio_t gpio_status,
	input side_ch_pkg::tsf_t tsf_runtime_val,
	input side_ch_pkg::len_t m_axis_data_count,
	input side_ch_pkg::addr_t wr_ptr,
	input side_ch_pkg::word_t rd_data,
	output logic buf_wr_en,
	output side_ch_pkg::word_t buf_wr_data,
	output side_ch_pkg::addr_t rd_addr,
	output side_ch_pkg::word_t data_to_ps,
	output logic data_to_ps_valid
);

	side_ch_pkg::cap_state_t state;
	side_ch_pkg::tsf_t tsf_lat;
	side_ch_pkg::len_t cnt; // strobes consumed in this burst
	logic pend; // read issued, word due next cycle
	logic space_ok;

	assign buf_wr_en = iq_strobe && cfg.capture_en;
	// status mode trades iq1 for rssi and agc status
	assign buf_wr_data = cfg.status_mode ?
		{5'd0, rssi_half_db, gpio_status, 8'd0, iq0} : {iq1, iq0};

	// header plus samples must fit in the dma fifo
	assign space_ok = (side_ch_pkg::MAX_DMA_WORDS - int'(m_axis_data_count)) >=
		(int'(cfg.iq_len) + 1);

	always_ff @(posedge clk) begin
		if (!rstn || !cfg.capture_en) begin
			state <= side_ch_pkg::WAIT;
			cnt <= '0;
			pend <= 1'b0;
			data_to_ps_valid <= 1'b0;
			if (!rstn) begin
				rd_addr <= '0;
			end
		end else begin
			data_to_ps_valid <= 1'b0;
			pend <= 1'b0;
			case (state)
				side_ch_pkg::WAIT: begin
					cnt <= '0;
					if (trigger) begin
						rd_addr <= wr_ptr - side_ch_pkg::addr_t'(cfg.pre_len);
						state <= side_ch_pkg::PREPARE;
					end
				end
				side_ch_pkg::PREPARE: begin
					state <= space_ok ? side_ch_pkg::HEADER : side_ch_pkg::WAIT;
				end
				side_ch_pkg::HEADER: begin
					data_to_ps_valid <= 1'b1; // timestamp word
					state <= side_ch_pkg::STREAM;
				end
				side_ch_pkg::STREAM: begin
					data_to_ps_valid <= pend;
					if (iq_strobe && cnt < cfg.iq_len) begin
						rd_addr <= rd_addr + side_ch_pkg::addr_t'(1);
						cnt <= cnt + side_ch_pkg::len_t'(1);
						pend <= 1'b1;
					end
					if (cnt >= cfg.iq_len && !pend) begin
						state <= side_ch_pkg::WAIT; // last word already out
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == side_ch_pkg::WAIT && trigger) begin
			tsf_lat <= tsf_runtime_val;
		end
		if (state == side_ch_pkg::HEADER) begin
			data_to_ps <= tsf_lat;
		end else if (pend) begin
			data_to_ps <= rd_data;
		end
	end

	a_idle_quiet: assert property (
		@(posedge clk) disable iff (!rstn)
		state inside {side_ch_pkg::WAIT, side_ch_pkg::PREPARE} |-> !data_to_ps_valid
	);

endmodule

// File: side_ch_top.sv
// iq capture side channel
`timescale 1ns/10ps

module side_ch_top (
	input logic clk,
	input logic rstn,
	input side_ch_pkg::apb_addr_t paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input side_ch_pkg::apb_data_t pwdata,
	output side_ch_pkg::apb_data_t prdata,
	output logic pready,
	input logic fcs_in_strobe,
	input logic fcs_ok,
	input logic pkt_header_valid_strobe,
	input logic long_preamble_detected,
	input logic short_preamble_detected,
	input logic phy_tx_started,
	input logic phy_tx_done,
	input logic tx_bb_is_ongoing,
	input side_ch_pkg::rssi_t rssi_half_db,
	input side_ch_pkg::gpio_t gpio_status,
	input side_ch_pkg::iq_w_t iq0,
	input side_ch_pkg::iq_w_t iq1,
	input logic iq_strobe,
	input side_ch_pkg::tsf_t tsf_runtime_val,
	input side_ch_pkg::len_t m_axis_data_count,
	output logic start_trans,
	output side_ch_pkg::word_t data_to_ps,
	output logic data_to_ps_valid
);

	logic trigger;
	logic buf_wr_en;
	side_ch_pkg::word_t buf_wr_data;
	side_ch_pkg::addr_t wr_ptr;
	side_ch_pkg::addr_t rd_addr;
	side_ch_pkg::word_t rd_data;

	side_ch_cfg_if cfg_if ();

	side_ch_regs u_regs (
		.clk, .rstn, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready,
		.start_trans, .cfg(cfg_if.regs)
	);

	iq_trigger_detect u_trig (
		.clk, .rstn, .cfg(cfg_if.trig), .fcs_in_strobe, .fcs_ok, .pkt_header_valid_strobe,
		.long_preamble_detected, .short_preamble_detected, .phy_tx_started, .phy_tx_done,
		.tx_bb_is_ongoing, .rssi_half_db, .gpio_status, .trigger
	);

	iq_ring_buffer u_buf (
		.clk, .rstn, .wr_en(buf_wr_en), .wr_data(buf_wr_data), .wr_ptr, .rd_addr, .rd_data
	);

	iq_capture_seq u_seq (
		.clk, .rstn, .cfg(cfg_if.seq), .trigger, .iq_strobe, .iq0, .iq1, .rssi_half_db,
		.gpio_status, .tsf_runtime_val, .m_axis_data_count, .wr_ptr, .rd_data, .buf_wr_en,
		.buf_wr_data, .rd_addr, .data_to_ps, .data_to_ps_valid
	);

endmodule

// File: tb_side_ch.sv
// side channel capture testbench
`timescale 1ns/10ps

module tb_side_ch;

	logic clk, rstn, psel, penable, pwrite, pready, iq_strobe, start_trans, data_to_ps_valid;
	logic fcs_in_strobe, fcs_ok, pkt_header_valid_strobe, long_preamble_detected;
	logic short_preamble_detected, phy_tx_started, phy_tx_done, tx_bb_is_ongoing;
	side_ch_pkg::apb_addr_t paddr;
	side_ch_pkg::apb_data_t pwdata, prdata;
	side_ch_pkg::rssi_t rssi_half_db;
	side_ch_pkg::gpio_t gpio_status;
	side_ch_pkg::iq_w_t iq0, iq1;
	side_ch_pkg::tsf_t tsf_runtime_val;
	side_ch_pkg::len_t m_axis_data_count;
	side_ch_pkg::word_t data_to_ps;
	side_ch_pkg::word_t exp_mem [0:4095]; // expected output words in order
	logic [11:0] exp_wr, exp_rd;
	logic [31:0] idx, rnd;
	logic strobe_run, run_s, strobe_s, start_exp;
	int errors, pre_cur, len_cur;

	side_ch_top dut (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// strobe every other cycle, sample index in iq0, timer frozen while paused
	always @(posedge clk) begin
		run_s = strobe_run;
		strobe_s = iq_strobe;
		#1;
		if (strobe_s) idx = idx + 32'd1;
		if (run_s) tsf_runtime_val = tsf_runtime_val + 64'd1;
		iq_strobe = run_s && !strobe_s;
		iq0 = idx;
		iq1 = ~idx;
	end

	always @(posedge clk) begin
		if (data_to_ps_valid && exp_rd != exp_wr) exp_rd <= exp_rd + 12'd1;
	end

	a_start: assert property (@(posedge clk) disable iff (!rstn) start_trans == start_exp)
		else begin
			errors++;
			$display("Mismatch at %0t: start_trans expected %b actual %b", $time,
				$sampled(start_exp), $sampled(start_trans));
		end

	a_ready: assert property (@(posedge clk) disable iff (!rstn) psel && penable |-> pready)
		else begin
			errors++;
			$display("Mismatch at %0t: pready expected 1 actual %b", $time, $sampled(pready));
		end

	a_no_extra: assert property (@(posedge clk) disable iff (!rstn)
		data_to_ps_valid |-> exp_rd != exp_wr)
		else begin
			errors++;
			$display("%0t: output word %h arrived when none was expected", $time,
				$sampled(data_to_ps));
		end

	a_word: assert property (@(posedge clk) disable iff (!rstn)
		data_to_ps_valid && exp_rd != exp_wr |-> data_to_ps == exp_mem[exp_rd])
		else begin
			errors++;
			$display("Mismatch at %0t: data_to_ps expected %h actual %h", $time,
				$sampled(exp_mem[exp_rd]), $sampled(data_to_ps));
		end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic side_ch_pkg::word_t sample_word(input logic [31:0] n, input logic st);
		return st ? {5'd0, rssi_half_db, gpio_status, 8'd0, n} : {~n, n};
	endfunction

	task automatic apb_write(input side_ch_pkg::apb_addr_t a, input side_ch_pkg::apb_data_t d);
		paddr = a;
		pwdata = d;
		pwrite = 1'b1;
		psel = 1'b1;
		@(posedge clk);
		#1 penable = 1'b1;
		@(posedge clk);
		#1 psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		start_exp = (a == side_ch_pkg::REG_LEN); // dma start due in this cycle only
		@(posedge clk);
		#1 start_exp = 1'b0;
	endtask

	task automatic apb_check(input side_ch_pkg::apb_addr_t a, input side_ch_pkg::apb_data_t e);
		paddr = a;
		pwrite = 1'b0;
		psel = 1'b1;
		@(posedge clk);
		#1 penable = 1'b1;
		#1 assert (prdata == e) else begin
			errors++;
			$display("Mismatch at %0t: prdata expected %h actual %h", $time, e, prdata);
		end
		@(posedge clk);
		#1 psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic set_lengths(input int pre, input int len);
		pre_cur = pre;
		len_cur = len;
		apb_write(side_ch_pkg::REG_PRE, 32'(pre));
		apb_write(side_ch_pkg::REG_LEN, 32'(len));
		repeat (2 * pre + 10) @(posedge clk); // fill the buffer
		#1;
	endtask

	task automatic fire(input int ev);
		case (ev)
			0: pkt_header_valid_strobe = 1'b1;
			1: rssi_half_db = 11'sd150;
			2: rssi_half_db = 11'sd50;
			3: gpio_status = {1'b1, 7'd60};
			4: gpio_status = {1'b1, 7'd20};
			5: fcs_in_strobe = 1'b1;
			6: phy_tx_started = 1'b1;
			default: tx_bb_is_ongoing = ~tx_bb_is_ongoing;
		endcase
		@(posedge clk);
		#1 pkt_header_valid_strobe = 1'b0;
		fcs_in_strobe = 1'b0;
		phy_tx_started = 1'b0;
	endtask

	task automatic pause_strobes();
		strobe_run = 1'b0;
		repeat (3) @(posedge clk);
		#1;
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (exp_rd != exp_wr && n < 4000) begin
			@(posedge clk);
			n++;
		end
		#1;
		if (exp_rd != exp_wr) begin
			errors++;
			$display("%0t: burst incomplete, %0d words missing", $time, exp_wr - exp_rd);
		end
	endtask

	// expected burst is queued before the event, strobes frozen meanwhile
	task automatic burst(input int ev, input logic st);
		logic [31:0] first;
		pause_strobes();
		first = idx - 32'(pre_cur);
		exp_mem[exp_wr] = tsf_runtime_val;
		exp_wr = exp_wr + 12'd1;
		for (int k = 0; k < len_cur; k++) begin
			exp_mem[exp_wr] = sample_word(first + 32'(k), st);
			exp_wr = exp_wr + 12'd1;
		end
		fire(ev);
		repeat (6) @(posedge clk);
		#1 strobe_run = 1'b1;
		wait_drain();
	endtask

	task automatic quiet(input int ev);
		pause_strobes();
		fire(ev);
		repeat (12) @(posedge clk);
		#1 strobe_run = 1'b1;
		repeat (20) @(posedge clk);
		#1;
	endtask

	initial begin
		{rstn, psel, penable, pwrite, iq_strobe, strobe_run} = '0;
		{fcs_in_strobe, fcs_ok, pkt_header_valid_strobe, long_preamble_detected} = '0;
		{short_preamble_detected, phy_tx_started, phy_tx_done, tx_bb_is_ongoing} = '0;
		paddr = '0;
		pwdata = '0;
		rssi_half_db = 11'sd50;
		gpio_status = {1'b1, 7'd20};
		{iq0, iq1, idx} = '0;
		tsf_runtime_val = 64'h0123_4567_0000_0000;
		m_axis_data_count = '0;
		{exp_wr, exp_rd} = '0;
		start_exp = 1'b0;
		errors = 0;
		rnd = 32'h6653de4b;
		repeat (16) @(posedge clk);
		#1 rstn = 1'b1;
		strobe_run = 1'b1;

		apb_write(side_ch_pkg::REG_CTRL, 32'h3);
		apb_write(side_ch_pkg::REG_TRIG, 32'hffff_fff9);
		apb_write(side_ch_pkg::REG_TH, 32'hffff_ffff);
		apb_write(side_ch_pkg::REG_PRE, 32'h1234_5678);
		apb_write(side_ch_pkg::REG_LEN, 32'h0000_2abc);
		apb_write(5'h14, 32'hdead_beef);
		apb_check(side_ch_pkg::REG_CTRL, 32'h3);
		apb_check(side_ch_pkg::REG_TRIG, 32'h9);
		apb_check(side_ch_pkg::REG_TH, 32'h007f_07ff);
		apb_check(side_ch_pkg::REG_PRE, 32'h1678);
		apb_check(side_ch_pkg::REG_LEN, 32'h2abc);
		apb_check(5'h14, 32'h0);

		apb_write(side_ch_pkg::REG_CTRL, 32'h1);
		apb_write(side_ch_pkg::REG_TRIG, 32'(side_ch_pkg::TRIG_HEADER_STROBE));
		apb_write(side_ch_pkg::REG_TH, {9'd0, 7'd40, 5'd0, 11'd100});
		set_lengths(5, 7);
		burst(0, 1'b0);
		for (int i = 0; i < 4; i++) begin
			rnd = xorshift(rnd);
			set_lengths(int'(rnd % 32'd200) + 1, int'((rnd >> 8) % 32'd64) + 1);
			burst(0, 1'b0);
		end

		rssi_half_db = 11'sd300; // status fields
		gpio_status = 8'h95;
		apb_write(side_ch_pkg::REG_CTRL, 32'h3);
		set_lengths(8, 12);
		burst(0, 1'b1);
		apb_write(side_ch_pkg::REG_CTRL, 32'h1);
		rssi_half_db = 11'sd50;
		gpio_status = {1'b1, 7'd20};

		m_axis_data_count = 14'(side_ch_pkg::MAX_DMA_WORDS - len_cur);
		set_lengths(8, 12);
		quiet(0); // one word short of space
		m_axis_data_count = 14'(side_ch_pkg::MAX_DMA_WORDS - len_cur - 1);
		burst(0, 1'b0);
		m_axis_data_count = '0;

		apb_write(side_ch_pkg::REG_TRIG, 32'(side_ch_pkg::TRIG_RSSI_RISE));
		set_lengths(4, 6);
		burst(1, 1'b0);
		quiet(2);
		apb_write(side_ch_pkg::REG_TRIG, 32'(side_ch_pkg::TRIG_GAIN_FALL));
		set_lengths(4, 6);
		quiet(3);
		burst(4, 1'b0);

		apb_write(side_ch_pkg::REG_TRIG, 32'(side_ch_pkg::TRIG_HEADER_STROBE));
		quiet(5);
		quiet(6);
		quiet(7);
		quiet(7);
		apb_write(side_ch_pkg::REG_CTRL, 32'h0);
		quiet(0);

		repeat (4) @(posedge clk);
		$display("checks done, errors: %0d", errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	initial begin
		#2_000_000;
		$display("timeout: simulation did not reach its end");
		$display("Some tests failed");
		$finish;
	end

endmodule

// File: vlog.f
side_ch_pkg.sv
side_ch_cfg_if.sv
side_ch_regs.sv
iq_trigger_detect.sv
iq_ring_buffer.sv
iq_capture_seq.sv
side_ch_top.sv
tb_side_ch.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert --top-module tb_side_ch -f vlog.f -o tb_sim > build.log 2>&1 &&
./obj_dir/tb_sim > sim.log 2>&1 || { echo "build or simulation error"; exit 1; }
grep -q "All tests passed" sim.log && exit 0 || exit 1
